/* bcd_accel.f */
+incdir+verification
src/bcd_pkg.sv
src/bcd_digit_add.sv
src/bcd_add_pipe.sv
src/bcd_latency_timer.sv
src/bcd_seq.sv
src/bcd_regs.sv
src/bcd_accel.sv
verification/bcd_accel_tb.sv

/* Makefile */
TOP = bcd_accel_tb
SRCS = $(shell grep -v '^+' bcd_accel.f) verification/bcd_model.svh

.PHONY: all run clean

all: run

obj_dir/V$(TOP): bcd_accel.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f bcd_accel.f

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

/* verification/bcd_model.svh */
`ifndef bcd_model_svh
`define bcd_model_svh
`default_nettype none

// reference arithmetic on packed BCD numbers of up to 32 digits
// digit i sits in bits [4*i+3:4*i], digits above ndig are ignored and return zero

// decimal sum with carry in, the carry out of the top digit comes back in bit 128
function automatic logic [128:0] dec_add(input logic [127:0] a, input logic [127:0] b,
	input logic ci, input int ndig);
	logic [127:0] r;
	int c;
	int s;
	r = '0;
	c = ci ? 1 : 0;
	for (int i = 0; i < ndig; i++) begin
		s = int'(a[i*4 +: 4]) + int'(b[i*4 +: 4]) + c;
		c = s / 10;
		r[i*4 +: 4] = 4'(s % 10);
	end
	return {c[0], r};
endfunction

// schoolbook subtraction with a borrow per digit
// bit 128 is set when nothing was borrowed out of the top digit, so when a >= b
function automatic logic [128:0] dec_sub(input logic [127:0] a, input logic [127:0] b,
	input int ndig);
	logic [127:0] r;
	int br;
	int d;
	r = '0;
	br = 0;
	for (int i = 0; i < ndig; i++) begin
		d = int'(a[i*4 +: 4]) - int'(b[i*4 +: 4]) - br;
		if (d < 0) begin
			d = d + 10;
			br = 1;
		end else begin
			br = 0;
		end
		r[i*4 +: 4] = 4'(d);
	end
	return {br == 0, r};
endfunction

// true when every one of the ndig nibbles holds a decimal digit
function automatic logic digits_valid(input logic [127:0] v, input int ndig);
	logic ok;
	ok = 1'b1;
	for (int i = 0; i < ndig; i++) begin
		if (v[i*4 +: 4] > 4'd9)
			ok = 1'b0;
	end
	return ok;
endfunction

`default_nettype wire
`endif

/* verification/bcd_accel_tb.sv */
`timescale 1ns/10ps
`include "bcd_model.svh"
`default_nettype none

module bcd_accel_tb;
	import bcd_pkg::*;

	localparam int nw = 2;
	localparam int ndig = nw * 8;
	localparam int n_rand = 200;
	localparam int n_bad = 10;
	// status reads allowed before a job counts as stuck
	localparam int poll_max = 16;
	// request edge, ack edge and release edge of one bus access
	localparam int acc_cycles = 3;
	// operand writes, start, polls and result reads of one job
	localparam int job_cycles = acc_cycles * (3 * nw + 2 + poll_max);
	localparam int n_jobs = 2 * n_rand + 3 * n_bad + 10;
	localparam int timeout_cycles = n_jobs * job_cycles + 200;

	logic clk;
	logic rst;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	int seed;
	int cycle_cnt;

	bcd_accel #(
		.NW(nw)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

	always #5 clk = ~clk;

	// watchdog over the whole run
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("timeout: run did not finish within %0d clock cycles", timeout_cycles);
			$display("=== FAIL ===");
			$fatal(1);
		end
	end

	// ----------------------------------------
	// reporting
	// ----------------------------------------
	task automatic abort_run(input string why);
		$display("error at %0t ns: %s", $time, why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_eq(input string what, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	// ----------------------------------------
	// wishbone master
	// ----------------------------------------

	// one classic cycle holds the request until ack and releases it on the next edge
	task automatic bus_cycle(input logic we, input logic [5:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waits;
		waits = 0;
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		// ack and read data are looked at on the falling edge, well clear of updates
		@(negedge clk);
		while (!wb_rsp.ack) begin
			if (waits == 4)
				abort_run("slave gave no ack within four cycles");
			waits++;
			@(negedge clk);
		end
		rdat = wb_rsp.dat;
		@(posedge clk);
		wb_req <= '{cyc: 1'b0, stb: 1'b0, we: 1'b0, adr: 6'd0, dat: 32'd0};
	endtask

	task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [5:0] adr, output logic [31:0] dat);
		bus_cycle(1'b0, adr, 32'd0, dat);
	endtask

	// ----------------------------------------
	// job level helpers
	// ----------------------------------------

	// random number of ndig decimal digits
	function automatic logic [127:0] rand_bcd();
		logic [127:0] v;
		v = '0;
		for (int i = 0; i < ndig; i++)
			v[i*4 +: 4] = 4'($unsigned($random(seed)) % 10);
		return v;
	endfunction

	task automatic write_operands(input logic [127:0] a, input logic [127:0] b);
		for (int w = 0; w < nw; w++)
			wb_write(reg_a_base + 6'(w), a[w*32 +: 32]);
		for (int w = 0; w < nw; w++)
			wb_write(reg_a_base + 6'(nw + w), b[w*32 +: 32]);
	endtask

	task automatic start_job(input bcd_op_e op);
		wb_write(reg_ctrl, {30'd0, op, 1'b1});
	endtask

	// poll the status word until the job reports done or err
	task automatic wait_done(output logic [3:0] st);
		logic [31:0] d;
		int polls;
		st = 4'd0;
		polls = 0;
		while (!st[2] && !st[0]) begin
			if (polls == poll_max)
				abort_run("status never showed done or err while polling");
			wb_read(reg_status, d);
			st = d[3:0];
			polls++;
		end
	endtask

	task automatic read_result(output logic [127:0] r);
		logic [31:0] d;
		r = '0;
		for (int w = 0; w < nw; w++) begin
			wb_read(reg_a_base + 6'(2 * nw + w), d);
			r[w*32 +: 32] = d;
		end
	endtask

	task automatic run_job(input logic [127:0] a, input logic [127:0] b, input bcd_op_e op,
		output logic [127:0] res, output logic [3:0] st);
		write_operands(a, b);
		start_job(op);
		wait_done(st);
		read_result(res);
	endtask

	// runs a full job and expects the model's result with done set and err and busy clear
	task automatic check_job(input logic [127:0] a, input logic [127:0] b, input bcd_op_e op,
		output logic [127:0] res);
		logic [128:0] exp;
		logic [3:0] st;
		if (op == op_add)
			exp = dec_add(a, b, 1'b0, ndig);
		else
			exp = dec_sub(a, b, ndig);
		run_job(a, b, op, res, st);
		check_eq("result", res, exp[127:0]);
		check_eq("status", {124'd0, st}, {124'd0, 1'b0, 1'b1, exp[128], 1'b0});
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic reset_readback();
		logic [31:0] d;
		logic [127:0] a;
		logic [127:0] b;
		logic [127:0] r;
		wb_read(reg_status, d);
		check_eq("status after reset", {96'd0, d}, 128'd0);
		read_result(r);
		check_eq("result after reset", r, 128'd0);
		a = rand_bcd();
		b = rand_bcd();
		write_operands(a, b);
		for (int w = 0; w < nw; w++) begin
			wb_read(reg_a_base + 6'(w), d);
			check_eq("operand a read back", {96'd0, d}, {96'd0, a[w*32 +: 32]});
			wb_read(reg_a_base + 6'(nw + w), d);
			check_eq("operand b read back", {96'd0, d}, {96'd0, b[w*32 +: 32]});
		end
	endtask

	task automatic random_adds();
		logic [127:0] r;
		for (int j = 0; j < n_rand; j++)
			check_job(rand_bcd(), rand_bcd(), op_add, r);
	endtask

	task automatic random_subs();
		logic [127:0] a;
		logic [127:0] b;
		logic [127:0] r;
		int n_gt;
		n_gt = 0;
		for (int j = 0; j < n_rand; j++) begin
			a = rand_bcd();
			b = rand_bcd();
			// every tenth job subtracts a number from itself
			if (j % 10 == 0)
				b = a;
			// packed BCD orders the same way as the binary vectors
			if (b > a)
				n_gt++;
			check_job(a, b, op_sub, r);
		end
		if (n_gt == 0)
			abort_run("subtraction runs never had b greater than a");
	endtask

	task automatic invalid_digits();
		logic [127:0] a;
		logic [127:0] b;
		logic [127:0] prev;
		logic [127:0] r;
		logic [3:0] st;
		logic [3:0] bad;
		logic ok;
		int pos;
		for (int j = 0; j < n_bad; j++) begin
			check_job(rand_bcd(), rand_bcd(), op_add, prev);
			a = rand_bcd();
			b = rand_bcd();
			pos = int'($unsigned($random(seed)) % ndig);
			bad = 4'(10 + $unsigned($random(seed)) % 6);
			if ($random(seed) & 1)
				a[pos*4 +: 4] = bad;
			else
				b[pos*4 +: 4] = bad;
			ok = digits_valid(a, ndig) && digits_valid(b, ndig);
			run_job(a, b, op_sub, r, st);
			// carry is left from the last good job, so only done and err count here
			check_eq("done and err after bad digits", {124'd0, st & 4'b0101},
				{124'd0, 1'b0, ok, 1'b0, !ok});
			check_eq("result after bad digits", r, prev);
			// the next good start has to clear err again
			check_job(rand_bcd(), rand_bcd(), op_sub, r);
		end
	endtask

	task automatic worst_case_busy();
		logic [127:0] nines;
		logic [127:0] a;
		logic [127:0] b;
		logic [127:0] r;
		logic [128:0] exp;
		logic [31:0] d;
		logic [3:0] st;
		nines = '0;
		for (int i = 0; i < ndig; i++)
			nines[i*4 +: 4] = 4'd9;
		// both cases send a carry through every lane of the adder
		check_job(nines, 128'd0, op_sub, r);
		check_job(nines, nines, op_add, r);
		a = rand_bcd();
		b = rand_bcd();
		write_operands(a, b);
		start_job(op_add);
		// lands while the job is still in the pipe
		wb_write(reg_a_base, ~a[31:0]);
		wait_done(st);
		exp = dec_add(a, b, 1'b0, ndig);
		read_result(r);
		check_eq("result with write during busy", r, exp[127:0]);
		check_eq("status with write during busy", {124'd0, st},
			{124'd0, 1'b0, 1'b1, exp[128], 1'b0});
		wb_read(reg_a_base, d);
		check_eq("operand a after write during busy", {96'd0, d}, {96'd0, a[31:0]});
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin : main
		seed = 32'h0d88_9127;
		cycle_cnt = 0;
		clk = 1'b0;
		rst = 1'b1;
		wb_req = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		reset_readback();
		random_adds();
		random_subs();
		invalid_digits();
		worst_case_busy();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* src/bcd_accel.sv */
`timescale 1ns/10ps
`default_nettype none

// decimal add and subtract accelerator behind a wishbone classic slave
// operands are NW words of packed BCD, eight digits per word
module bcd_accel #(
	parameter int NW = 2
) (
	input logic clk,
	input logic rst,
	input bcd_pkg::wb_req_t wb_req,
	output bcd_pkg::wb_rsp_t wb_rsp
);

	// control between register file and sequencer
	logic start;
	logic digit_ok;
	logic busy;
	logic result_we;
	logic set_err;
	logic timer_load;
	logic expired;

	// adder datapath, four byte lanes per word
	logic [NW*32-1:0] add_a;
	logic [NW*32-1:0] add_b;
	logic add_ci;
	logic [NW*32-1:0] sum;
	logic co;

	bcd_regs #(
		.NW(NW)
	) u_regs (
		.clk(clk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.busy(busy),
		.result_we(result_we),
		.set_err(set_err),
		.start(start),
		.digit_ok(digit_ok),
		.add_a(add_a),
		.add_b(add_b),
		.sum(sum),
		.add_ci(add_ci),
		.co(co)
	);

	bcd_seq u_seq (
		.clk(clk),
		.rst(rst),
		.start(start),
		.digit_ok(digit_ok),
		.expired(expired),
		.timer_load(timer_load),
		.busy(busy),
		.result_we(result_we),
		.set_err(set_err)
	);

	bcd_latency_timer u_timer (
		.clk(clk),
		.rst(rst),
		.load(timer_load),
		.expired(expired)
	);

	bcd_add_pipe #(
		.N(4 * NW)
	) u_pipe (
		.clk(clk),
		.a(add_a),
		.b(add_b),
		.ci(add_ci),
		.sum(sum),
		.co(co)
	);

endmodule

`default_nettype wire

/* src/bcd_regs.sv */
`timescale 1ns/10ps
`default_nettype none

// wishbone classic slave holding the operands, the opcode, the result and status
// it also prepares the adder inputs and checks that every operand digit is 0 to 9
module bcd_regs #(
	parameter int NW = 2
) (
	input logic clk,
	input logic rst,
	input bcd_pkg::wb_req_t wb_req,
	output bcd_pkg::wb_rsp_t wb_rsp,
	input logic busy,
	input logic result_we,
	input logic set_err,
	output logic start,
	output logic digit_ok,
	output logic [NW*32-1:0] add_a,
	output logic [NW*32-1:0] add_b,
	input logic [NW*32-1:0] sum,
	output logic add_ci,
	input logic co
);
	import bcd_pkg::*;

	localparam logic [5:0] reg_b_base = reg_a_base + 6'(NW);
	localparam logic [5:0] reg_r_base = reg_a_base + 6'(2 * NW);

	logic ack_q;
	logic [wb_dw-1:0] rdat;
	logic [wb_dw-1:0] rdat_q;
	logic [NW*32-1:0] a_q;
	logic [NW*32-1:0] b_q;
	logic [NW*32-1:0] res_q;
	bcd_op_e op_q;
	logic done_q;
	logic carry_q;
	logic err_q;
	bcd_status_t status;
	logic req;
	logic wr_ok;

	assign req = wb_req.cyc && wb_req.stb;
	// writes land in the ack cycle, and never while a job is starting or running
	assign wr_ok = req && wb_req.we && ack_q && !busy && !start;

	assign status = '{busy: busy, done: done_q, carry: carry_q, err: err_q};

	// ----------------------------------------
	// read decode where unmapped words read zero
	// ----------------------------------------
	always_comb begin
		rdat = '0;
		if (wb_req.adr == reg_ctrl)
			rdat = {{(wb_dw-2){1'b0}}, op_q, 1'b0};
		if (wb_req.adr == reg_status)
			rdat = {{(wb_dw-4){1'b0}}, status};
		for (int w = 0; w < NW; w++) begin
			if (wb_req.adr == reg_a_base + 6'(w))
				rdat = a_q[w*32 +: 32];
			if (wb_req.adr == reg_b_base + 6'(w))
				rdat = b_q[w*32 +: 32];
			if (wb_req.adr == reg_r_base + 6'(w))
				rdat = res_q[w*32 +: 32];
		end
	end

	// ----------------------------------------
	// bus handshake, register writes, status
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			rdat_q <= '0;
			start <= 1'b0;
			op_q <= op_add;
			a_q <= '0;
			b_q <= '0;
			res_q <= '0;
			done_q <= 1'b0;
			carry_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			// one wait cycle, then ack for exactly one cycle
			ack_q <= req && !ack_q;
			rdat_q <= rdat;
			start <= wr_ok && (wb_req.adr == reg_ctrl) && wb_req.dat[0];
			if (wr_ok) begin
				if (wb_req.adr == reg_ctrl)
					op_q <= bcd_op_e'(wb_req.dat[1]);
				for (int w = 0; w < NW; w++) begin
					if (wb_req.adr == reg_a_base + 6'(w))
						a_q[w*32 +: 32] <= wb_req.dat;
					if (wb_req.adr == reg_b_base + 6'(w))
						b_q[w*32 +: 32] <= wb_req.dat;
				end
			end
			// a new job wipes the outcome of the last one
			if (start) begin
				done_q <= 1'b0;
				err_q <= 1'b0;
			end
			if (result_we) begin
				res_q <= sum;
				carry_q <= co;
				done_q <= 1'b1;
			end
			// the previous result stays untouched on an error
			if (set_err)
				err_q <= 1'b1;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdat_q;

	// ----------------------------------------
	// adder operands and digit check
	// ----------------------------------------
	always_comb begin
		add_a = a_q;
		add_ci = (op_q == op_sub);
		// subtract adds the nines' complement of B, digit by digit
		for (int i = 0; i < NW*8; i++) begin
			if (op_q == op_sub)
				add_b[i*4 +: 4] = 4'd9 - b_q[i*4 +: 4];
			else
				add_b[i*4 +: 4] = b_q[i*4 +: 4];
		end
	end

	always_comb begin
		digit_ok = 1'b1;
		for (int i = 0; i < NW*8; i++) begin
			if (a_q[i*4 +: 4] > 4'd9 || b_q[i*4 +: 4] > 4'd9)
				digit_ok = 1'b0;
		end
	end

	// ack answers a request that the master still holds, and never lasts two cycles
	a_ack_single: assert property (@(posedge clk) disable iff (rst)
		wb_rsp.ack |-> req && !$past(wb_rsp.ack));

endmodule

`default_nettype wire

/* src/bcd_seq.sv */
`timescale 1ns/10ps
`default_nettype none

// runs one job at a time through the adder pipe
// a start with bad digits only raises the error flag and stays idle
module bcd_seq (
	input logic clk,
	input logic rst,
	input logic start,
	input logic digit_ok,
	input logic expired,
	output logic timer_load,
	output logic busy,
	output logic result_we,
	output logic set_err
);
	import bcd_pkg::*;

	seq_state_e state;

	// ----------------------------------------
	// state register and pulses
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			timer_load <= 1'b0;
			set_err <= 1'b0;
		end else begin
			// both pulses last a single cycle
			timer_load <= 1'b0;
			set_err <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin
						if (digit_ok) begin
							// operands already sit at the pipe inputs
							timer_load <= 1'b1;
							state <= st_run;
						end else begin
							set_err <= 1'b1;
						end
					end
				end
				st_run: begin
					// the sum is valid while expired is high
					if (expired)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// ----------------------------------------
	// outputs decoded from the state
	// ----------------------------------------
	assign busy = (state == st_run);

	// capture in the cycle the timer runs out, four cycles after start
	assign result_we = (state == st_run) && expired;

	// a capture only closes a job that loaded the timer one latency earlier
	a_result_in_run: assert property (@(posedge clk) disable iff (rst)
		result_we |-> (state == st_run) && $past(timer_load, add_latency));

endmodule

`default_nettype wire

/* src/bcd_latency_timer.sv */
`timescale 1ns/10ps
`default_nettype none

// counts the adder latency down after a load
// expired is high in the last cycle of the count, add_latency cycles after load
module bcd_latency_timer (
	input logic clk,
	input logic rst,
	input logic load,
	output logic expired
);
	import bcd_pkg::*;

	logic [1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= 2'd0;
		end else if (load) begin
			cnt <= 2'(add_latency);
		end else if (cnt != 2'd0) begin
			cnt <= cnt - 2'd1;
		end
	end

	// the count reaches zero on the next edge
	assign expired = (cnt == 2'd1);

	// every expiry belongs to a load exactly one latency earlier
	a_expired_after_load: assert property (@(posedge clk) disable iff (rst)
		expired |-> $past(load, add_latency));

endmodule

`default_nettype wire

/* src/bcd_add_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

// N byte lanes of packed BCD, added in add_latency registered rows
// the first row adds a and b lane by lane and keeps each lane carry to itself
// middle rows add the carries of the row before, shifted up one lane
// the last row takes its lane carries from a lookahead across runs of 99 lanes,
// so a carry that has to ripple through several lanes still lands in one cycle
module bcd_add_pipe #(
	parameter int N = 8
) (
	input logic clk,
	input logic [N*8-1:0] a,
	input logic [N*8-1:0] b,
	input logic ci,
	output logic [N*8-1:0] sum,
	output logic co
);
	import bcd_pkg::*;

	localparam int rows = add_latency;
	localparam int last = rows - 1;

	// combinational cell outputs of every row
	logic [N*8-1:0] row_o [rows];
	logic [N-1:0] row_d [rows];
	// one-bit carry fed into each lane, row 0 only sees ci in lane 0
	logic [N-1:0] row_sh [rows];
	// registered sums and lane carries between rows
	logic [N*8-1:0] row_s [last];
	logic [N-1:0] row_c [last];
	// top-lane carries gathered so far, one register per row
	logic [last-1:0] row_t;
	logic [N-1:0] last_cin;

	assign row_sh[0] = {{(N-1){1'b0}}, ci};
	assign row_sh[last] = last_cin;

	// ----------------------------------------
	// rows of digit cells
	// ----------------------------------------
	for (genvar k = 0; k < rows; k++) begin : g_row
		for (genvar g = 0; g < N; g++) begin : g_lane
			if (k == 0) begin : g_first
				bcd_digit_add u_cell (
					.a(a[g*8 +: 8]),
					.b(b[g*8 +: 8]),
					.ci(row_sh[0][g]),
					.o(row_o[0][g*8 +: 8]),
					.co(row_d[0][g])
				);
			end else begin : g_next
				// later rows add a single carry bit to the previous sum
				bcd_digit_add u_cell (
					.a(row_s[k-1][g*8 +: 8]),
					.b({7'd0, row_sh[k][g]}),
					.ci(1'b0),
					.o(row_o[k][g*8 +: 8]),
					.co(row_d[k][g])
				);
			end
		end
		if (k > 0 && k < last) begin : g_shift
			assign row_sh[k] = {row_c[k-1][N-2:0], 1'b0};
		end
	end

	// carry into each lane of the last row, passed on through lanes sitting at 99
	always_comb begin
		logic cy;
		cy = 1'b0;
		for (int g = 0; g < N; g++) begin
			last_cin[g] = cy;
			cy = row_c[last-1][g] | (cy & (row_s[last-1][g*8 +: 8] == 8'h99));
		end
	end

	// ----------------------------------------
	// row registers and output
	// ----------------------------------------
	for (genvar k = 0; k < last; k++) begin : g_reg
		always_ff @(posedge clk) begin
			row_s[k] <= row_o[k];
			row_c[k] <= row_d[k];
		end
		// the top lane carry leaves the adder instead of shifting up
		if (k == 0) begin : g_t0
			always_ff @(posedge clk)
				row_t[0] <= row_d[0][N-1];
		end else begin : g_tn
			always_ff @(posedge clk)
				row_t[k] <= row_t[k-1] | row_d[k][N-1];
		end
	end

	always_ff @(posedge clk) begin
		sum <= row_o[last];
		co <= row_t[last-1] | row_d[last][N-1];
	end

	// a lane holding a carry from the row above can never overflow again in the
	// last row, so merging both carries into the lookahead loses nothing
	a_no_double_carry: assert property (@(posedge clk) (row_c[last-1] & row_d[last]) == '0);

endmodule

`default_nettype wire

/* src/bcd_digit_add.sv */
`timescale 1ns/10ps
`default_nettype none

// adds one byte lane, that is two packed BCD digits, plus a carry in
// the result is a valid BCD byte and a decimal carry out of the lane
module bcd_digit_add (
	input logic [7:0] a,
	input logic [7:0] b,
	input logic ci,
	output logic [7:0] o,
	output logic co
);

	// one decimal digit position, returns {carry, digit}
	function automatic logic [4:0] nib_add(input logic [3:0] x, input logic [3:0] y,
		input logic c);
		logic [4:0] raw;
		raw = {1'b0, x} + {1'b0, y} + {4'd0, c};
		// anything past nine wraps by adding six, which also clears the 4-bit overflow
		if (raw > 5'd9)
			nib_add = {1'b1, raw[3:0] + 4'd6};
		else
			nib_add = {1'b0, raw[3:0]};
	endfunction

	logic [4:0] lo;
	logic [4:0] hi;

	always_comb begin
		// low digit first, its carry ripples straight into the high digit
		lo = nib_add(a[3:0], b[3:0], ci);
		hi = nib_add(a[7:4], b[7:4], lo[4]);
		o = {hi[3:0], lo[3:0]};
		co = hi[4];
	end

endmodule

`default_nettype wire

/* src/bcd_pkg.sv */
`default_nettype none

package bcd_pkg;

	// ----------------------------------------
	// bus and pipeline constants
	// ----------------------------------------

	// width of the wishbone data bus
	localparam int wb_dw = 32;

	// clock cycles from stable operands to a registered sum
	// this is also the number of adder rows in the pipe
	localparam int add_latency = 3;

	// ----------------------------------------
	// register map, word addresses
	// ----------------------------------------

	localparam logic [5:0] reg_ctrl = 6'd0;
	localparam logic [5:0] reg_status = 6'd1;
	// operand B and the result follow A, each NW words long
	localparam logic [5:0] reg_a_base = 6'd2;

	// ----------------------------------------
	// enums and bus structs
	// ----------------------------------------

	// subtract uses the nines' complement of B with carry in set
	typedef enum logic {
		op_add = 1'b0,
		op_sub = 1'b1
	} bcd_op_e;

	typedef enum logic {
		st_idle = 1'b0,
		st_run = 1'b1
	} seq_state_e;

	// master to slave, held stable until ack
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [5:0] adr;
		logic [wb_dw-1:0] dat;
	} wb_req_t;

	// slave to master, read data is valid together with ack
	typedef struct packed {
		logic ack;
		logic [wb_dw-1:0] dat;
	} wb_rsp_t;

	// low four bits of the status word, err in bit 0
	typedef struct packed {
		logic busy;
		logic done;
		logic carry;
		logic err;
	} bcd_status_t;

endpackage

`default_nettype wire
